//--- arithTypes.sv
/* Data widths of the arithmetic unit and the typedefs of its data vectors. */

`default_nettype none

package arithTypes;

  localparam int DataWidth  = 16;                // Accumulator width.
  localparam int HalfWidth  = 8;                 // Multiplier operand width.
  localparam int GroupWidth = 4;                 // Width of one lookahead group.
  localparam int MultSteps  = 8;                 // One iteration per multiplier bit.

  typedef logic [DataWidth-1:0] dataWord;        // Accumulator, operand and product.
  typedef logic [HalfWidth-1:0] halfWord;        // One half of an operand.
  typedef logic [1:0]           shiftAmt;        // Right shift count for SHR.

endpackage

`default_nettype wire

//--- arithCtrl.sv
/* Host opcodes, command and response structs, accumulator operations
   and the control state encoding. */

`default_nettype none

package arithCtrl;

  ////////////////////
  // Host side.

  typedef enum logic [2:0] {
    OpClear, OpLoad, OpAdd, OpSub, OpMac, OpShr
  } opCode;

  typedef struct packed {
    opCode               op;                     // Requested operation.
    arithTypes::dataWord operand;                // Data word or packed halves.
  } hostCmd;

  typedef struct packed {
    arithTypes::dataWord acc;                    // Accumulator after the command.
    logic                carry;                  // Carry out of the last operation.
  } hostRsp;

  ////////////////////
  // Internal sequencing.

  typedef enum logic [2:0] {
    AccHold, AccClear, AccLoad, AccAdd, AccSub, AccMac, AccShr
  } accOp;

  typedef enum logic [2:0] {
    Idle, Exec, MultWait, Accum, Ack, Release
  } ctrlState;

endpackage

`default_nettype wire

//--- claAdder.sv
/* Combinational 16-bit carry-lookahead adder with four 4-bit groups
   and a block carry unit. */

`default_nettype none

module claAdder
(
  input  arithTypes::dataWord a,
  input  arithTypes::dataWord b,
  input  logic                cin,
  output arithTypes::dataWord sum,
  output logic                cout
);

  arithTypes::dataWord bitProp;                  // Per bit propagate.
  arithTypes::dataWord bitGen;                   // Per bit generate.

  logic [arithTypes::DataWidth/arithTypes::GroupWidth-1:0] grpProp;
  logic [arithTypes::DataWidth/arithTypes::GroupWidth-1:0] grpGen;
  logic [arithTypes::DataWidth/arithTypes::GroupWidth:0]   grpCarry;

  assign bitProp = a ^ b;
  assign bitGen  = a & b;

  ////////////////////
  // Block lookahead unit.

  assign grpCarry[0] = cin;
  assign grpCarry[1] = grpGen[0] | (grpProp[0] & cin);
  assign grpCarry[2] = grpGen[1] | (grpProp[1] & grpGen[0])
                     | (grpProp[1] & grpProp[0] & cin);
  assign grpCarry[3] = grpGen[2] | (grpProp[2] & grpGen[1])
                     | (grpProp[2] & grpProp[1] & grpGen[0])
                     | (grpProp[2] & grpProp[1] & grpProp[0] & cin);
  assign grpCarry[4] = grpGen[3] | (grpProp[3] & grpGen[2])
                     | (grpProp[3] & grpProp[2] & grpGen[1])
                     | (grpProp[3] & grpProp[2] & grpProp[1] & grpGen[0])
                     | (grpProp[3] & grpProp[2] & grpProp[1] & grpProp[0] & cin);
  assign cout = grpCarry[4];

  ////////////////////
  // Lookahead inside each group.

  for (genvar k = 0; k < arithTypes::DataWidth / arithTypes::GroupWidth; k++)
  begin : group
    logic [arithTypes::GroupWidth-1:0] prop;
    logic [arithTypes::GroupWidth-1:0] gen;
    logic [arithTypes::GroupWidth-1:0] inCarry; // Carry into each bit of the group.

    assign prop = bitProp[k*arithTypes::GroupWidth +: arithTypes::GroupWidth];
    assign gen  = bitGen[k*arithTypes::GroupWidth +: arithTypes::GroupWidth];

    assign inCarry[0] = grpCarry[k];
    assign inCarry[1] = gen[0] | (prop[0] & grpCarry[k]);
    assign inCarry[2] = gen[1] | (prop[1] & gen[0]) | (prop[1] & prop[0] & grpCarry[k]);
    assign inCarry[3] = gen[2] | (prop[2] & gen[1]) | (prop[2] & prop[1] & gen[0])
                      | (prop[2] & prop[1] & prop[0] & grpCarry[k]);

    assign grpProp[k] = &prop;                   // Group passes a carry straight through.
    assign grpGen[k]  = gen[3] | (prop[3] & gen[2]) | (prop[3] & prop[2] & gen[1])
                      | (prop[3] & prop[2] & prop[1] & gen[0]);

    assign sum[k*arithTypes::GroupWidth +: arithTypes::GroupWidth] = prop ^ inCarry;
  end

endmodule

`default_nettype wire

//--- shiftAddMult.sv
/* Iterative 8x8 unsigned shift-add multiplier with start and done. */

`default_nettype none

module shiftAddMult
(
  input  logic                C,
  input  logic                CLR,
  input  logic                start,
  input  arithTypes::halfWord multiplicand,
  input  arithTypes::halfWord multiplier,
  output arithTypes::dataWord product,
  output logic                done
);

  arithTypes::dataWord mcandReg;                 // Multiplicand, shifted left each step.
  arithTypes::halfWord mplierReg;                // Multiplier, shifted right each step.
  arithTypes::dataWord partial;                  // Running partial product.
  arithTypes::dataWord stepSum;
  logic                busy;
  logic [$clog2(arithTypes::MultSteps)-1:0] stepCount;

  claAdder stepAdder
  (
    .a    (partial),
    .b    (mcandReg),
    .cin  (1'b0),
    .sum  (stepSum),
    .cout ()                                     // An 8x8 product never exceeds 16 bits.
  );

  ////////////////////
  // Step sequencing.

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      busy      <= 1'b0;
      stepCount <= '0;
      done      <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        busy      <= 1'b1;
        stepCount <= '0;
      end
      else if (busy)
      begin
        stepCount <= stepCount + 1;
        if (int'(stepCount) == arithTypes::MultSteps - 1)
        begin
          busy <= 1'b0;
          done <= 1'b1;                          // Partial product is final at this edge.
        end
      end
    end
  end

  always_ff @(posedge C)
  begin
    if (start)
    begin
      mcandReg  <= {{(arithTypes::DataWidth - arithTypes::HalfWidth){1'b0}}, multiplicand};
      mplierReg <= multiplier;
      partial   <= '0;
    end
    else if (busy)
    begin
      if (mplierReg[0])
        partial <= stepSum;                      // Add this weight of the multiplicand.
      mcandReg  <= mcandReg << 1;
      mplierReg <= mplierReg >> 1;
    end
  end

  assign product = partial;

endmodule

`default_nettype wire

//--- accumUnit.sv
/* Accumulator and carry registers, next value selection and shift divider. */

`default_nettype none

module accumUnit
(
  input  logic                C,
  input  logic                CLR,
  input  arithCtrl::accOp     operation,
  input  arithTypes::dataWord operand,
  input  arithTypes::dataWord product,
  output arithTypes::dataWord acc,
  output logic                carry
);

  arithTypes::dataWord adderB;
  logic                adderCin;
  arithTypes::dataWord adderSum;
  logic                adderCout;
  arithTypes::shiftAmt shiftCount;
  arithTypes::dataWord accNext;
  logic                carryNext;

  claAdder accAdder
  (
    .a    (acc),
    .b    (adderB),
    .cin  (adderCin),
    .sum  (adderSum),
    .cout (adderCout)
  );

  assign shiftCount = operand[1:0];              // Divide by 1, 2, 4 or 8.

  always_comb
  begin
    adderB   = operand;
    adderCin = 1'b0;
    case (operation)
      arithCtrl::AccSub:
      begin
        adderB   = ~operand;                     // Two's complement subtraction.
        adderCin = 1'b1;
      end
      arithCtrl::AccMac: adderB = product;
      default: ;
    endcase
  end

  always_comb
  begin
    accNext   = acc;
    carryNext = carry;
    case (operation)
      arithCtrl::AccClear:
      begin
        accNext   = '0;
        carryNext = 1'b0;
      end
      arithCtrl::AccLoad:
      begin
        accNext   = operand;
        carryNext = 1'b0;
      end
      arithCtrl::AccAdd, arithCtrl::AccSub, arithCtrl::AccMac:
      begin
        accNext   = adderSum;
        carryNext = adderCout;                   // For SUB this means no borrow.
      end
      arithCtrl::AccShr:
      begin
        accNext   = acc >> shiftCount;           // Zeros enter at the top.
        carryNext = 1'b0;
      end
      default: ;
    endcase
  end

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      acc   <= '0;
      carry <= 1'b0;
    end
    else
    begin
      acc   <= accNext;
      carry <= carryNext;
    end
  end

endmodule

`default_nettype wire

//--- arithControl.sv
/* Control FSM for the req/ack handshake and command sequencing. */

`default_nettype none

module arithControl
(
  input  logic            C,
  input  logic            CLR,
  input  logic            req,
  input  arithCtrl::opCode op,
  output logic            ack,
  output arithCtrl::accOp accOperation,
  output logic            multStart,
  input  logic            multDone
);

  arithCtrl::ctrlState state;
  arithCtrl::ctrlState nextState;

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
      state <= arithCtrl::Idle;
    else
      state <= nextState;
  end

  ////////////////////
  // Next state and datapath controls.

  always_comb
  begin
    nextState    = state;
    accOperation = arithCtrl::AccHold;
    multStart    = 1'b0;
    case (state)
      arithCtrl::Idle:
      begin
        if (req)
          nextState = arithCtrl::Exec;
      end
      arithCtrl::Exec:
      begin
        if (op == arithCtrl::OpMac)
        begin
          multStart = 1'b1;                      // Multiplier samples the halves here.
          nextState = arithCtrl::MultWait;
        end
        else
        begin
          case (op)
            arithCtrl::OpClear: accOperation = arithCtrl::AccClear;
            arithCtrl::OpLoad:  accOperation = arithCtrl::AccLoad;
            arithCtrl::OpAdd:   accOperation = arithCtrl::AccAdd;
            arithCtrl::OpSub:   accOperation = arithCtrl::AccSub;
            arithCtrl::OpShr:   accOperation = arithCtrl::AccShr;
            default:            accOperation = arithCtrl::AccHold;
          endcase
          nextState = arithCtrl::Ack;            // Accumulator updates at the same edge.
        end
      end
      arithCtrl::MultWait:
      begin
        if (multDone)
          nextState = arithCtrl::Accum;
      end
      arithCtrl::Accum:
      begin
        accOperation = arithCtrl::AccMac;
        nextState    = arithCtrl::Ack;
      end
      arithCtrl::Ack:
      begin
        if (!req)
          nextState = arithCtrl::Release;        // Host has taken the response.
      end
      arithCtrl::Release: nextState = arithCtrl::Idle;
      default:            nextState = arithCtrl::Idle;
    endcase
  end

  // Response is complete for as long as the FSM sits in Ack.
  assign ack = (state == arithCtrl::Ack);

endmodule

`default_nettype wire

//--- arithUnit.sv
/* Top level of the serial arithmetic unit with control and datapath. */

`default_nettype none

module arithUnit
(
  input  logic              C,
  input  logic              CLR,
  input  logic              req,
  input  arithCtrl::hostCmd cmd,
  output logic              ack,
  output arithCtrl::hostRsp rsp
);

  arithCtrl::accOp     accOperation;
  logic                multStart;
  logic                multDone;
  arithTypes::halfWord multiplicand;
  arithTypes::halfWord multiplier;
  arithTypes::dataWord product;
  arithTypes::dataWord acc;
  logic                carry;

  assign multiplicand = cmd.operand[arithTypes::DataWidth-1:arithTypes::HalfWidth];
  assign multiplier   = cmd.operand[arithTypes::HalfWidth-1:0];

  arithControl control
  (
    .C            (C),
    .CLR          (CLR),
    .req          (req),
    .op           (cmd.op),
    .ack          (ack),
    .accOperation (accOperation),
    .multStart    (multStart),
    .multDone     (multDone)
  );

  shiftAddMult mult
  (
    .C            (C),
    .CLR          (CLR),
    .start        (multStart),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .product      (product),
    .done         (multDone)
  );

  accumUnit accum
  (
    .C         (C),
    .CLR       (CLR),
    .operation (accOperation),
    .operand   (cmd.operand),
    .product   (product),
    .acc       (acc),
    .carry     (carry)
  );

  assign rsp = '{acc: acc, carry: carry};

endmodule

`default_nettype wire

//--- tbArithChecker.sv
/* Testbench checker with the reference model, the shadow accumulator
   and the error counters. */

`default_nettype none

module tbArithChecker
(
  input  logic              C,
  input  logic              CLR,
  input  logic              req,
  input  arithCtrl::hostCmd cmd,
  input  logic              ack,
  input  arithCtrl::hostRsp rsp,
  input  logic [2:0]        phase,
  output int                checkCount,
  output int                valueErrors,
  output int                protocolErrors
);

  timeunit 1ns;
  timeprecision 1ps;

  arithCtrl::hostRsp shadow;                     // Accumulator and carry after the last command.
  arithCtrl::hostRsp heldRsp;                    // Response seen at the rise of ack.
  arithCtrl::hostRsp expected;
  logic              ackSeen;
  logic              reqSeen;

  function automatic string testName(input logic [2:0] p);
    case (p)
      3'd1:    return "reset";
      3'd2:    return "add";
      3'd3:    return "sub";
      3'd4:    return "mac";
      3'd5:    return "shift";
      3'd6:    return "backpressure";
      3'd7:    return "mixed";
      default: return "startup";
    endcase
  endfunction

  ////////////////////
  // Reference model.

  function automatic arithCtrl::hostRsp applyCommand(input arithCtrl::hostRsp prev,
                                                     input arithCtrl::hostCmd c);
    arithCtrl::hostRsp   next;
    logic [16:0]         wide;
    arithTypes::dataWord prod;
    next = prev;
    prod = {8'h00, c.operand[15:8]} * {8'h00, c.operand[7:0]};
    case (c.op)
      arithCtrl::OpClear:
      begin
        next.acc   = '0;
        next.carry = 1'b0;
      end
      arithCtrl::OpLoad:
      begin
        next.acc   = c.operand;
        next.carry = 1'b0;
      end
      arithCtrl::OpAdd:
      begin
        wide       = {1'b0, prev.acc} + {1'b0, c.operand};
        next.acc   = wide[15:0];
        next.carry = wide[16];                   // Set when the sum leaves 16 bits.
      end
      arithCtrl::OpSub:
      begin
        next.acc   = prev.acc - c.operand;
        next.carry = (prev.acc >= c.operand);    // No borrow.
      end
      arithCtrl::OpMac:
      begin
        wide       = {1'b0, prev.acc} + {1'b0, prod};
        next.acc   = wide[15:0];
        next.carry = wide[16];
      end
      arithCtrl::OpShr:
      begin
        next.acc   = prev.acc / (16'd1 << c.operand[1:0]);
        next.carry = 1'b0;
      end
      default: ;
    endcase
    return next;
  endfunction

  ////////////////////
  // Handshake monitor.

  always @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      shadow         <= '0;
      heldRsp        <= '0;
      ackSeen        <= 1'b0;
      reqSeen        <= 1'b0;
      checkCount     <= 0;
      valueErrors    <= 0;
      protocolErrors <= 0;
    end
    else
    begin
      ackSeen <= ack;
      reqSeen <= req;
      if (ack && !ackSeen)
      begin
        expected = applyCommand(shadow, cmd);   // The command is still held by req here.
        shadow     <= expected;
        heldRsp    <= rsp;
        checkCount <= checkCount + 1;
        if (rsp !== expected)
        begin
          valueErrors <= valueErrors + 1;
          $display("CHECK FAILED %s: %s expected acc=%h carry=%b, actual acc=%h carry=%b",
                   testName(phase), cmd.op.name(), expected.acc, expected.carry,
                   rsp.acc, rsp.carry);
        end
      end
      else if (ack && rsp !== heldRsp)
      begin
        protocolErrors <= protocolErrors + 1;
        $display("Test %s: the response changed while ack was high", testName(phase));
      end
      if (!ack && ackSeen && reqSeen)
      begin
        protocolErrors <= protocolErrors + 1;
        $display("Test %s: ack fell while req was still high", testName(phase));
      end
    end
  end

endmodule

`default_nettype wire

//--- tbArithUnit.sv
/* Testbench top with clock, reset, the req/ack host driver and the stimulus. */

`default_nettype none

module tbArithUnit;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int AckTimeout     = 40;            // A MAC takes about a dozen cycles.
  localparam int ReleaseTimeout = 8;

  logic              C;
  logic              CLR;
  logic              req;
  logic              ack;
  arithCtrl::hostCmd cmd;
  arithCtrl::hostRsp rsp;
  logic [2:0]        phase;
  int                checkCount;
  int                valueErrors;
  int                protocolErrors;
  int                timeouts    = 0;
  int                localErrors = 0;
  int                sentCount   = 0;

  arithUnit uut
  (
    .C   (C),
    .CLR (CLR),
    .req (req),
    .cmd (cmd),
    .ack (ack),
    .rsp (rsp)
  );

  tbArithChecker scoreboard
  (
    .C              (C),
    .CLR            (CLR),
    .req            (req),
    .cmd            (cmd),
    .ack            (ack),
    .rsp            (rsp),
    .phase          (phase),
    .checkCount     (checkCount),
    .valueErrors    (valueErrors),
    .protocolErrors (protocolErrors)
  );

  initial
  begin
    C = 1'b0;
    forever #10 C = ~C;                          // 20 ns period.
  end

  function automatic arithCtrl::hostCmd makeCmd(input arithCtrl::opCode op,
                                                input arithTypes::dataWord operand);
    arithCtrl::hostCmd c;
    c.op      = op;
    c.operand = operand;
    return c;
  endfunction

  function automatic arithCtrl::hostCmd randomCmd();
    return makeCmd(arithCtrl::opCode'(3'($urandom_range(5, 0))), 16'($urandom));
  endfunction

  task automatic endRun();
    if (checkCount != sentCount)
    begin
      localErrors++;
      $display("The checker compared %0d responses for %0d commands sent",
               checkCount, sentCount);
    end
    $display("Checks: %0d, value errors: %0d, protocol errors: %0d, timeouts: %0d",
             checkCount, valueErrors, protocolErrors + localErrors, timeouts);
    if (valueErrors + protocolErrors + localErrors + timeouts == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  endtask

  task automatic giveUp(input string what);
    timeouts++;
    $display("Timeout: %s", what);
    endRun();
  endtask

  ////////////////////
  // Host side of the handshake.

  task automatic sendCommand(input arithCtrl::hostCmd c, input int extraHold);
    int cycles;
    int hold;
    hold = int'($urandom_range(5, 0)) + extraHold; // Extra cycles with req held after ack.
    @(posedge C);
    req <= 1'b1;
    cmd <= c;
    sentCount++;
    cycles = 0;
    while (ack !== 1'b1 && cycles < AckTimeout)
    begin
      @(posedge C);
      cycles++;
    end
    if (ack !== 1'b1)
      giveUp("ack did not rise after req");
    else
    begin
      repeat (hold) @(posedge C);
      req <= 1'b0;
      cycles = 0;
      while (ack !== 1'b0 && cycles < ReleaseTimeout)
      begin
        @(posedge C);
        cycles++;
      end
      if (ack !== 1'b0)
        giveUp("ack did not fall after req was dropped");
    end
  endtask

  ////////////////////
  // Stimulus.

  initial
  begin
    void'($urandom(32'h384a));
    CLR   <= 1'b1;
    req   <= 1'b0;
    cmd   <= '0;
    phase <= 3'd0;
    repeat (8) @(posedge C);
    CLR <= 1'b0;
    @(posedge C);
    phase <= 3'd1;
    if (ack !== 1'b0)
    begin
      localErrors++;
      $display("ack is not low after reset");
    end
    sendCommand(makeCmd(arithCtrl::OpLoad, 16'h0000), 0);
    sendCommand(makeCmd(arithCtrl::OpAdd, 16'h0000), 0);
    sendCommand(makeCmd(arithCtrl::OpLoad, 16'($urandom)), 0);
    sendCommand(makeCmd(arithCtrl::OpAdd, 16'($urandom)), 0);
    sendCommand(makeCmd(arithCtrl::OpClear, 16'($urandom)), 0);

    phase <= 3'd2;
    sendCommand(makeCmd(arithCtrl::OpLoad, 16'hFFFF), 0);
    sendCommand(makeCmd(arithCtrl::OpAdd, 16'h0001), 0);   // Wraps to zero with carry.
    sendCommand(makeCmd(arithCtrl::OpLoad, 16'h8000), 0);
    sendCommand(makeCmd(arithCtrl::OpAdd, 16'h8000), 0);
    repeat (20)
    begin
      sendCommand(makeCmd(arithCtrl::OpLoad, 16'($urandom)), 0);
      sendCommand(makeCmd(arithCtrl::OpAdd, 16'($urandom)), 0);
    end

    phase <= 3'd3;
    sendCommand(makeCmd(arithCtrl::OpLoad, 16'd100), 0);
    sendCommand(makeCmd(arithCtrl::OpSub, 16'd30), 0);
    sendCommand(makeCmd(arithCtrl::OpSub, 16'd200), 0);     // Borrow.
    sendCommand(makeCmd(arithCtrl::OpLoad, 16'h1234), 0);
    sendCommand(makeCmd(arithCtrl::OpSub, 16'h1234), 0);
    repeat (20)
    begin
      sendCommand(makeCmd(arithCtrl::OpLoad, 16'($urandom)), 0);
      sendCommand(makeCmd(arithCtrl::OpSub, 16'($urandom)), 0);
    end

    phase <= 3'd4;
    sendCommand(makeCmd(arithCtrl::OpClear, 16'h0000), 0);
    sendCommand(makeCmd(arithCtrl::OpMac, 16'h0000), 0);
    sendCommand(makeCmd(arithCtrl::OpMac, 16'h0101), 0);
    sendCommand(makeCmd(arithCtrl::OpMac, 16'hFFFF), 0);
    sendCommand(makeCmd(arithCtrl::OpLoad, 16'hFFFF), 0);
    sendCommand(makeCmd(arithCtrl::OpMac, 16'h0101), 0);   // Product of one overflows acc.
    repeat (20)
    begin
      sendCommand(makeCmd(arithCtrl::OpLoad, 16'($urandom)), 0);
      sendCommand(makeCmd(arithCtrl::OpMac, 16'($urandom)), 0);
    end

    phase <= 3'd5;
    for (int s = 0; s < 4; s++)
    begin
      repeat (5)
      begin
        sendCommand(makeCmd(arithCtrl::OpLoad, 16'($urandom)), 0);
        sendCommand(makeCmd(arithCtrl::OpShr, (16'($urandom) & 16'hFFFC) | 16'(s)), 0);
      end
    end

    phase <= 3'd6;
    repeat (6)
      sendCommand(randomCmd(), 20);              // Host stalls with req held high.

    phase <= 3'd7;
    repeat (300)
      sendCommand(randomCmd(), 0);

    repeat (2) @(posedge C);
    endRun();
  end

endmodule

`default_nettype wire

//--- project.f
arithTypes.sv
arithCtrl.sv
claAdder.sv
shiftAddMult.sv
accumUnit.sv
arithControl.sv
arithUnit.sv
tbArithChecker.sv
tbArithUnit.sv

//--- Makefile
# Verilator build and run of the arithmetic unit testbench.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module tbArithUnit -f project.f \
		-Mdir obj_dir -o simArith
	./obj_dir/simArith | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
